/* hw/pkt_pkg.sv */
`default_nettype none

// Shared widths, depths and vector types of the packet forwarder
package pkt_pkg;

	// One input word as it arrives on the strobe interface
	localparam int WORD_W = 32;

	// One memory flit holds two input words and is also the TDATA width
	localparam int FLIT_W = 64;

	// Number of flits the packet memory can hold
	localparam int MEM_DEPTH = 256;

	// Address width follows the memory depth
	localparam int ADDR_W = 8;

	// Packet lengths are counted in input words, up to 512 of them
	localparam int LEN_W = 10;

	typedef logic [WORD_W-1:0] word_t;

	typedef logic [FLIT_W-1:0] flit_t;

	typedef logic [ADDR_W-1:0] flit_addr_t;

	// A packet of N words fills (N+1)/2 flits starting at address zero
	typedef logic [LEN_W-1:0] pkt_len_t;

endpackage

`default_nettype wire

/* hw/pktmem_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Write side of the packet memory, driven by the packet writer
interface pktmem_wr_if;
	import pkt_pkg::*;

	// One flit write per cycle
	logic wr_en;
	flit_addr_t wr_addr;
	flit_t wr_data;

	// Commit strobe hands the finished packet and its word count to the memory
	logic commit;
	pkt_len_t commit_len;

	// High while the memory holds a packet that has not been forwarded yet
	logic full;

	modport writer (
		output wr_en, wr_addr, wr_data,
		output commit, commit_len,
		input full
	);

	modport mem (
		input wr_en, wr_addr, wr_data,
		input commit, commit_len,
		output full
	);

endinterface

// Read side of the packet memory, driven by the AXI Stream forwarder
interface pktmem_rd_if;
	import pkt_pkg::*;

	// rd_data is registered in the memory and valid the cycle after rd_en
	logic rd_en;
	flit_addr_t rd_addr;
	flit_t rd_data;

	// ready mirrors the occupancy flag and len is the committed word count
	logic ready;
	pkt_len_t len;

	// Single-cycle strobe on the read of the last flit
	logic done;

	modport fwd (
		output rd_en, rd_addr, done,
		input rd_data, ready, len
	);

	modport mem (
		input rd_en, rd_addr, done,
		output rd_data, ready, len
	);

endinterface

`default_nettype wire

/* hw/pkt_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_writer (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_last,
	input pkt_pkg::word_t in_data,
	output logic in_drop,
	pktmem_wr_if.writer wr
);
	import pkt_pkg::*;

	// IDLE waits for a first word, FILL packs an accepted packet, DISCARD swallows a dropped one
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		DISCARD
	} wr_state_t;

	wr_state_t state;

	// Low word of a flit waiting for its partner
	word_t lo_word;

	// Words accepted so far in the current packet; bit 0 picks the flit half
	pkt_len_t word_cnt;

	// Address the next finished flit goes to
	flit_addr_t flit_ptr;

	logic busy;
	logic accept;
	logic flit_done;
	logic drop_last;

	// A commit still in flight counts as busy since full only rises a cycle later
	assign busy = wr.full || wr.commit;

	// Words are taken while filling, or as the first word when the memory is free
	assign accept = in_valid && (state == FILL || (state == IDLE && !busy));

	// A flit is complete on every odd word and on the last word of the packet
	assign flit_done = accept && (word_cnt[0] || in_last);

	// Last word of a packet that found the memory occupied
	assign drop_last = in_valid && in_last &&
		(state == DISCARD || (state == IDLE && busy));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			word_cnt <= '0;
			flit_ptr <= '0;
			wr.wr_en <= 1'b0;
			wr.commit <= 1'b0;
			in_drop <= 1'b0;
		end else begin
			// Strobes last one cycle
			wr.wr_en <= flit_done;
			wr.commit <= accept && in_last;
			in_drop <= drop_last;

			// Every packet starts again at address zero
			if (flit_done) begin
				flit_ptr <= in_last ? '0 : flit_ptr + 1'b1;
			end

			if (accept) begin
				word_cnt <= in_last ? '0 : word_cnt + 1'b1;
			end

			case (state)
				IDLE: begin
					// Single-word packets finish in IDLE
					if (in_valid && !in_last) begin
						state <= busy ? DISCARD : FILL;
					end
				end
				FILL, DISCARD: begin
					if (in_valid && in_last) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data path of the flit being built
	always_ff @(posedge clk) begin
		if (accept && !word_cnt[0]) begin
			lo_word <= in_data;
		end
		if (flit_done) begin
			wr.wr_addr <= flit_ptr;
			// An odd packet ends on a lone low word with a zero upper half
			wr.wr_data <= word_cnt[0] ? {in_data, lo_word} : {{WORD_W{1'b0}}, in_data};
		end
		if (accept && in_last) begin
			wr.commit_len <= word_cnt + 1'b1;
		end
	end

	// The writer only commits into a free memory
	a_commit_not_full: assert property (@(posedge clk) disable iff (rst)
		!(wr.commit && wr.full))
		else $error("packet committed while the memory is full");

endmodule

`default_nettype wire

/* hw/pkt_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_mem (
	input logic clk,
	input logic rst,
	pktmem_wr_if.mem wr,
	pktmem_rd_if.mem rd
);
	import pkt_pkg::*;

	// Single-packet flit storage
	flit_t ram [MEM_DEPTH];

	// Set by a commit and cleared by done
	logic full;

	// Word count of the packet currently held
	pkt_len_t len_q;

	// Read data register
	flit_t rd_q;

	// Write port
	always_ff @(posedge clk) begin
		if (wr.wr_en) begin
			ram[wr.wr_addr] <= wr.wr_data;
		end
	end

	// Read port with the output register, which holds its value between reads
	always_ff @(posedge clk) begin
		if (rd.rd_en) begin
			rd_q <= ram[rd.rd_addr];
		end
	end

	// Occupancy flag
	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (wr.commit) begin
			full <= 1'b1;
		end else if (rd.done) begin
			// Memory becomes free the cycle after the last flit is read
			full <= 1'b0;
		end
	end

	// Each commit latches the word count of the packet it hands over
	always_ff @(posedge clk) begin
		if (wr.commit) begin
			len_q <= wr.commit_len;
		end
	end

	assign wr.full = full;
	assign rd.ready = full;
	assign rd.len = len_q;
	assign rd.rd_data = rd_q;

	// The forwarder reads only a committed packet
	a_read_when_full: assert property (@(posedge clk) disable iff (rst)
		!(rd.rd_en && !full))
		else $error("memory read while no packet is held");

endmodule

`default_nettype wire

/* hw/axis_forwarder.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_forwarder (
	input logic clk,
	input logic rst,
	pktmem_rd_if.fwd rd,
	output pkt_pkg::flit_t m_tdata,
	output logic m_tvalid,
	output logic m_tlast,
	input logic m_tready
);
	import pkt_pkg::*;

	// Word count minus one, halved, gives the address of the last flit
	pkt_len_t len_m1;
	flit_addr_t last_addr;

	// Current read address
	flit_addr_t rd_ptr;

	logic rd_go;
	logic at_last;

	assign len_m1 = rd.len - 1'b1;
	assign last_addr = flit_addr_t'(len_m1 >> 1);

	assign at_last = (rd_ptr == last_addr);

	// Read when a packet is held and the output register is empty or being drained
	assign rd_go = rd.ready && (m_tready || !m_tvalid);

	assign rd.rd_en = rd_go;
	assign rd.rd_addr = rd_ptr;

	// Reading the last flit releases the memory
	assign rd.done = rd_go && at_last;

	// TDATA comes straight from the memory's read register
	assign m_tdata = rd.rd_data;

	// Address walks up on each read and returns to zero after the last one
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (rd_go) begin
			rd_ptr <= at_last ? '0 : rd_ptr + 1'b1;
		end
	end

	// Output handshake register
	always_ff @(posedge clk) begin
		if (rst) begin
			m_tvalid <= 1'b0;
			m_tlast <= 1'b0;
		end else begin
			// A new read fills the register, a stall keeps it
			m_tvalid <= rd_go || (m_tvalid && !m_tready);
			if (rd_go) begin
				m_tlast <= at_last;
			end else if (m_tready) begin
				// Register drains without a refill
				m_tlast <= 1'b0;
			end
		end
	end

	// A stalled beat is neither withdrawn nor changed
	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
		else $error("AXI Stream beat changed while stalled");

endmodule

`default_nettype wire

/* hw/pkt_fwd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fwd_top (
	input logic clk,
	input logic rst,

	// Word strobe input, no back-pressure
	input logic in_valid,
	input pkt_pkg::word_t in_data,
	input logic in_last,
	output logic in_drop,

	// AXI Stream master
	output pkt_pkg::flit_t m_tdata,
	output logic m_tvalid,
	output logic m_tlast,
	input logic m_tready
);

	// Writer to memory
	pktmem_wr_if wr_if ();

	// Memory to forwarder
	pktmem_rd_if rd_if ();

	// Packs words into flits and commits the packet
	pkt_writer writer_i (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_last (in_last),
		.in_data (in_data),
		.in_drop (in_drop),
		.wr (wr_if.writer)
	);

	// Holds one packet at a time
	pkt_mem mem_i (
		.clk (clk),
		.rst (rst),
		.wr (wr_if.mem),
		.rd (rd_if.mem)
	);

	// Streams the held packet out
	axis_forwarder fwd_i (
		.clk (clk),
		.rst (rst),
		.rd (rd_if.fwd),
		.m_tdata (m_tdata),
		.m_tvalid (m_tvalid),
		.m_tlast (m_tlast),
		.m_tready (m_tready)
	);

endmodule

`default_nettype wire

/* verification/pkt_fwd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fwd_tb;
	import pkt_pkg::*;

	// Bound on any single wait, in clock cycles
	localparam int DRAIN_LIMIT = 2000;
	localparam int LATENCY_LIMIT = 20;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	word_t in_data;
	logic in_last;
	logic in_drop;
	flit_t m_tdata;
	logic m_tvalid;
	logic m_tlast;
	logic m_tready = 1'b0;

	// 0 holds m_tready low, 1 holds it high, anything else toggles it randomly
	int ready_mode = 1;

	// Expected stream, filled from the reference packing of every accepted packet
	flit_t exp_flits[$];
	logic exp_last[$];

	// Monitor state
	time xfer_times[$];
	time last_strobe_time;
	flit_t held_data;
	flit_t last_flit;
	logic stalled = 1'b0;
	int drop_cnt = 0;

	int waited;
	int n_words;

	pkt_fwd_top dut_i (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_data (in_data),
		.in_last (in_last),
		.in_drop (in_drop),
		.m_tdata (m_tdata),
		.m_tvalid (m_tvalid),
		.m_tlast (m_tlast),
		.m_tready (m_tready)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Word 2k fills the low half of flit k, word 2k+1 the high half, a missing word reads as zero
	function automatic void pack_expected(input word_t words[$]);
		int n_flits;
		word_t hi;
		n_flits = (words.size() + 1) / 2;
		for (int k = 0; k < n_flits; k++) begin
			if (2 * k + 1 < words.size()) begin
				hi = words[2 * k + 1];
			end else begin
				hi = '0;
			end
			exp_flits.push_back({hi, words[2 * k]});
			exp_last.push_back(k == n_flits - 1);
		end
	endfunction

	// One word per cycle; a dropped packet adds nothing to the expected stream
	task automatic send_packet(input int n, input bit dropped);
		word_t words[$];
		for (int i = 0; i < n; i++) begin
			words.push_back($urandom());
		end
		if (!dropped) begin
			pack_expected(words);
		end
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_data <= words[i];
			in_last <= (i == n - 1);
		end
		last_strobe_time = $time;
		@(posedge clk);
		in_valid <= 1'b0;
		in_last <= 1'b0;
		in_data <= '0;
	endtask

	// Changed away from the clock edge so the m_tready driver sees it cleanly
	task automatic set_ready_mode(input int mode);
		@(negedge clk);
		ready_mode = mode;
	endtask

	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while (exp_flits.size() != 0 || m_tvalid) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				fail_run("timed out waiting for the expected flits to come out");
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst || ready_mode == 0) begin
			m_tready <= 1'b0;
		end else if (ready_mode == 1) begin
			m_tready <= 1'b1;
		end else begin
			// Mostly ready, with frequent single and multi-cycle stalls
			m_tready <= ($urandom() % 4) != 0;
		end
	end

	// Outputs are sampled mid-cycle where every NBA has settled
	always @(negedge clk) begin
		if (!rst) begin
			if (stalled) begin
				check_eq(64'(m_tvalid), 64'd1, "m_tvalid fell during a stall");
				check_eq(m_tdata, held_data, "m_tdata changed during a stall");
			end
			stalled = m_tvalid && !m_tready;
			held_data = m_tdata;
			if (!m_tvalid) begin
				check_eq(64'(m_tlast), 64'd0, "m_tlast without m_tvalid");
			end
			if (in_drop) begin
				drop_cnt++;
			end
			if (m_tvalid && m_tready) begin
				if (exp_flits.size() == 0) begin
					fail_run("a flit was sent while no packet was expected");
				end
				check_eq(m_tdata, exp_flits.pop_front(), "m_tdata");
				check_eq(64'(m_tlast), 64'(exp_last.pop_front()), "m_tlast");
				xfer_times.push_back($time);
				if (m_tlast) begin
					last_flit = m_tdata;
				end
			end
		end
	end

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_last = 1'b0;
		void'($urandom(32'he227));
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Quiet outputs with no input
		repeat (10) begin
			@(negedge clk);
			check_eq(64'(m_tvalid), 64'd0, "m_tvalid after reset");
			check_eq(64'(m_tlast), 64'd0, "m_tlast after reset");
			check_eq(64'(in_drop), 64'd0, "in_drop after reset");
		end

		// Even packet into an empty memory, latency and back-to-back flits
		xfer_times.delete();
		send_packet(6, 1'b0);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > LATENCY_LIMIT) begin
				fail_run("m_tvalid never rose after the packet was sent");
			end
		end while (!m_tvalid);
		check_eq(($time - last_strobe_time - 5) / 10, 64'd3, "cycles from last strobe to m_tvalid");
		wait_drained(DRAIN_LIMIT);
		check_eq(64'(xfer_times.size()), 64'd3, "flit count of the even packet");
		for (int i = 1; i < xfer_times.size(); i++) begin
			check_eq(xfer_times[i] - xfer_times[i - 1], 64'd10, "gap between flits");
		end

		// Odd packet, last flit must carry a zero upper half
		send_packet(7, 1'b0);
		wait_drained(DRAIN_LIMIT);
		check_eq(64'(last_flit[63:32]), 64'd0, "upper half of the odd last flit");

		// Random back-pressure on a longer packet
		set_ready_mode(2);
		send_packet(30, 1'b0);
		wait_drained(DRAIN_LIMIT);

		// Second packet while the first is stuck behind a low m_tready
		set_ready_mode(0);
		send_packet(8, 1'b0);
		send_packet(5, 1'b1);
		@(negedge clk);
		check_eq(64'(in_drop), 64'd1, "in_drop after the dropped packet");
		repeat (4) @(negedge clk);
		check_eq(64'(drop_cnt), 64'd1, "number of drop pulses");
		set_ready_mode(1);
		wait_drained(DRAIN_LIMIT);

		// Back to back random packets under random back-pressure
		set_ready_mode(2);
		repeat (20) begin
			n_words = $urandom_range(1, 40);
			send_packet(n_words, 1'b0);
			wait_drained(DRAIN_LIMIT);
		end

		// A late stray flit would still trip the monitor here
		repeat (20) @(negedge clk);
		check_eq(64'(exp_flits.size()), 64'd0, "flits left in the expected queue");
		check_eq(64'(drop_cnt), 64'd1, "total drop pulses");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/pkt_pkg.sv
hw/pktmem_if.sv
hw/pkt_writer.sv
hw/pkt_mem.sv
hw/axis_forwarder.sv
hw/pkt_fwd_top.sv
verification/pkt_fwd_tb.sv

/* Makefile */
# Verilator simulation of the packet forwarder testbench

VERILATOR ?= verilator
TOP ?= pkt_fwd_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# The simulator's exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
